/* common/cmd_pkg.sv */
`default_nettype none

//////////////////////////////
// link words and command codes
//////////////////////////////
package cmd_pkg;

	typedef logic [31:0] word_t;                  // one link word, any position in a frame
	typedef logic [4:0]  cmd_code_t;              // low 5 bits of the CC word

	localparam cmd_code_t CC_LOOPBACK = 5'd0;     // echo the frame
	localparam cmd_code_t CC_RD_REG   = 5'd1;     // read one register
	localparam cmd_code_t CC_WR_REG   = 5'd2;     // write one register

	// receive stream content
	typedef struct packed {
		word_t data;                              // payload word
		logic  last;                              // final word of the frame
	} rx_beat_t;

	// transmit stream content
	typedef struct packed {
		word_t data;                              // reply word
		logic  last;                              // final word of the reply
	} tx_beat_t;

	// source of the next transmit word
	typedef enum logic [2:0] {
		SEL_CSN,                                  // channel serial number
		SEL_CMD,                                  // command word as received
		SEL_INV_CMD,                              // inverted command, error reply
		SEL_RX,                                   // receive word, loopback
		SEL_REG                                   // register read data
	} tx_sel_t;

endpackage

`default_nettype wire

/* common/reg_pkg.sv */
`default_nettype none

//////////////////////////////
// register bank definitions
//////////////////////////////
package reg_pkg;
	import cmd_pkg::*;

	typedef logic [7:0] reg_num_t;                // register number from the request frame

	localparam reg_num_t REG_CH_ADDR   = 8'd0;    // corrected channel address, read-only
	localparam reg_num_t REG_VERSION   = 8'd1;    // firmware version, read-only
	localparam reg_num_t REG_CTRL_BASE = 8'd2;    // first writable control register

	// width of the control register port, NUM_CTRL_REGS must not exceed this
	localparam int MAX_CTRL_REGS = 4;

	// register bank strobes from the control module
	typedef struct packed {
		logic num_le;                             // latch register number from rx data
		logic rd_en;                              // capture read data
		logic wr_en;                              // write rx data to the latched number
	} reg_req_t;

	// writable control registers, entry 0 is register REG_CTRL_BASE
	typedef word_t [MAX_CTRL_REGS-1:0] ctrl_regs_t;

endpackage

`default_nettype wire

/* register_bank/register_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module register_bank
	import cmd_pkg::*, reg_pkg::*;
#(
	parameter int    NUM_CTRL_REGS = 4,           // writable registers, up to MAX_CTRL_REGS
	parameter word_t FW_VERSION    = 32'h0001_0003
) (
	input  wire logic       clk,
	input  wire logic       reset,
	input  wire word_t      rx_data,              // register number or write data
	input  wire reg_req_t   reg_req,              // strobes from the control
	input  wire logic [2:0] ch_addr,              // channel address jumpers
	output logic            illegal_reg_num,      // latched number out of range
	output word_t           reg_rd_data,          // registered read data
	output ctrl_regs_t      ctrl_regs             // writable control registers
);

	logic [2:0] ch_addr_fixed;                    // jumper value after correction
	reg_num_t   reg_num;                          // latched register number
	word_t      ctrl_rd;                          // selected control register

	// channel 3 board has its jumpers set to 6
	always_ff @(posedge clk) begin
		ch_addr_fixed <= (ch_addr == 3'd6) ? 3'd3 : ch_addr;
	end

	//////////////////////////////
	// register number and range check
	always_ff @(posedge clk) begin
		if (reset)
			reg_num <= '0;
		else if (reg_req.num_le)
			reg_num <= reg_num_t'(rx_data);       // low byte of the number word
	end

	assign illegal_reg_num = (reg_num >= reg_num_t'(REG_CTRL_BASE + NUM_CTRL_REGS));

	//////////////////////////////
	// read path
	always_comb begin
		ctrl_rd = '0;
		for (int i = 0; i < NUM_CTRL_REGS; i++) begin
			if (reg_num == reg_num_t'(REG_CTRL_BASE + i)) ctrl_rd = ctrl_regs[i];
		end
	end

	always_ff @(posedge clk) begin
		if (reg_req.rd_en) begin
			case (reg_num)
				REG_CH_ADDR: reg_rd_data <= {29'd0, ch_addr_fixed};
				REG_VERSION: reg_rd_data <= FW_VERSION;
				default:     reg_rd_data <= ctrl_rd; // zero when out of range
			endcase
		end
	end

	//////////////////////////////
	// write path, read-only numbers fall through with no effect
	always_ff @(posedge clk) begin
		if (reset) begin
			ctrl_regs <= '0;                      // unused upper entries stay zero
		end else if (reg_req.wr_en && !illegal_reg_num) begin
			for (int i = 0; i < NUM_CTRL_REGS; i++) begin
				if (reg_num == reg_num_t'(REG_CTRL_BASE + i)) ctrl_regs[i] <= rx_data;
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/tx_frame_builder.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_frame_builder
	import cmd_pkg::*;
(
	input  wire logic    clk,
	input  wire logic    reset,
	input  wire word_t   rx_data,                 // receive word
	input  wire logic    load_csn,                // latch CSN from rx_data
	input  wire logic    load_cmd,                // latch CC from rx_data
	input  wire tx_sel_t tx_sel,                  // source for the next word
	input  wire logic    tx_load,                 // register the selected word
	input  wire logic    tx_last_in,              // last flag for that word
	input  wire word_t   reg_rd_data,             // register read data
	output cmd_code_t    cmd_code,                // code field back to the control
	output tx_beat_t     tx                       // transmit word and last
);

	word_t csn_reg;                               // channel serial number
	word_t cmd_reg;                               // full command word

	//////////////////////////////
	// header latches
	always_ff @(posedge clk) begin
		if (reset) begin
			csn_reg <= '0;
			cmd_reg <= '0;
		end else begin
			if (load_csn) csn_reg <= rx_data;
			if (load_cmd) cmd_reg <= rx_data;
		end
	end

	assign cmd_code = cmd_reg[4:0];               // only the low bits carry the code

	//////////////////////////////
	// transmit word register, held until the next load
	always_ff @(posedge clk) begin
		if (reset) begin
			tx.last <= 1'b0;
		end else if (tx_load) begin
			tx.last <= tx_last_in;
			case (tx_sel)
				SEL_CSN:     tx.data <= csn_reg;
				SEL_CMD:     tx.data <= cmd_reg;
				SEL_INV_CMD: tx.data <= ~cmd_reg; // error flag to the master
				SEL_RX:      tx.data <= rx_data;
				SEL_REG:     tx.data <= reg_rd_data;
				default:     tx.data <= csn_reg;
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/cmd_dispatch_sm.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_dispatch_sm
	import cmd_pkg::*, reg_pkg::*;
(
	input  wire logic      clk,
	input  wire logic      reset,
	input  wire logic      rx_last,               // final receive word of the frame
	input  wire logic      rx_tvalid,
	output logic           rx_tready,
	input  wire logic      tx_tready,
	output logic           tx_tvalid,
	input  wire cmd_code_t cmd_code,              // latched code from the frame builder
	input  wire logic      illegal_reg_num,       // from the register bank
	output logic           load_csn,
	output logic           load_cmd,
	output tx_sel_t        tx_sel,
	output logic           tx_load,
	output logic           tx_last_in,
	output reg_req_t       reg_req,
	output logic           command_idle
);

	typedef enum logic [3:0] {
		S_IDLE,                                   // wait for a frame
		S_GET_CSN,                                // accept serial number
		S_GET_CC,                                 // accept command word
		S_DISPATCH,                               // branch on the latched code
		S_LOOPBACK,                               // stream rx words to tx
		S_GET_NUM,                                // accept register number
		S_GET_DATA,                               // accept write data
		S_REG_ACCESS,                             // range check and read strobe
		S_SEND,                                   // reply header and register word
		S_DRAIN,                                  // discard rest of frame
		S_DONE                                    // wait for the final tx transfer
	} state_t;

	state_t     state, state_nxt;
	logic [1:0] word_idx;                         // reply word position in S_SEND
	logic       err;                              // reply with inverted CC
	logic       rx_ended;                         // rx last already accepted
	logic       tx_free;                          // tx register may take a new word
	logic       is_loop, is_rd, is_wr;
	logic       reply_final;                      // current reply word ends the frame

	assign tx_free      = !tx_tvalid || tx_tready; // empty, or emptying this cycle
	assign is_loop      = (cmd_code == CC_LOOPBACK);
	assign is_rd        = (cmd_code == CC_RD_REG);
	assign is_wr        = (cmd_code == CC_WR_REG);
	assign command_idle = (state == S_IDLE);

	// the CC ends an error reply, a write reply and a lone loopback header
	// the register word ends a good read
	assign reply_final = (word_idx == 2'd2) ||
		((word_idx == 2'd1) && (err || (is_loop ? rx_ended : is_wr)));

	//////////////////////////////
	// next state and strobes
	always_comb begin
		state_nxt  = state;
		rx_tready  = 1'b0;
		load_csn   = 1'b0;
		load_cmd   = 1'b0;
		tx_load    = 1'b0;
		tx_sel     = SEL_CSN;
		tx_last_in = 1'b0;
		reg_req    = '0;
		case (state)
			S_IDLE: if (rx_tvalid) state_nxt = S_GET_CSN;
			S_GET_CSN: begin
				rx_tready = 1'b1;
				if (rx_tvalid) begin
					load_csn  = 1'b1;
					state_nxt = rx_last ? S_DONE : S_GET_CC; // runt frame gets no reply
				end
			end
			S_GET_CC: begin
				rx_tready = 1'b1;
				if (rx_tvalid) begin
					load_cmd  = 1'b1;
					state_nxt = S_DISPATCH;
				end
			end
			S_DISPATCH: begin
				case (cmd_code)
					CC_LOOPBACK:          state_nxt = S_SEND;
					CC_RD_REG, CC_WR_REG: state_nxt = rx_ended ? S_SEND : S_GET_NUM;
					default:              state_nxt = rx_ended ? S_DONE : S_DRAIN;
				endcase
			end
			S_GET_NUM: begin
				rx_tready = 1'b1;
				if (rx_tvalid) begin
					reg_req.num_le = 1'b1;
					if (!is_wr)
						state_nxt = S_REG_ACCESS;
					else
						state_nxt = rx_last ? S_SEND : S_GET_DATA; // missing data is an error
				end
			end
			S_GET_DATA: begin
				rx_tready = 1'b1;
				if (rx_tvalid) begin
					reg_req.wr_en = 1'b1;         // bank drops it if the number is illegal
					state_nxt     = S_REG_ACCESS;
				end
			end
			S_REG_ACCESS: begin
				reg_req.rd_en = is_rd;            // data ready before word 2 is loaded
				state_nxt     = S_SEND;
			end
			S_SEND: begin
				if (tx_free) begin
					tx_load    = 1'b1;
					tx_last_in = reply_final;
					case (word_idx)
						2'd0:    tx_sel = SEL_CSN;
						2'd1:    tx_sel = err ? SEL_INV_CMD : SEL_CMD;
						default: tx_sel = SEL_REG;
					endcase
					if (reply_final)
						state_nxt = rx_ended ? S_DONE : S_DRAIN; // leftover words
					else if (is_loop && (word_idx == 2'd1))
						state_nxt = S_LOOPBACK;   // payload follows the header
				end
			end
			S_LOOPBACK: begin
				rx_tready = tx_free;              // stall rx while tx is held back
				if (rx_tvalid && tx_free) begin
					tx_load    = 1'b1;
					tx_sel     = SEL_RX;
					tx_last_in = rx_last;
					if (rx_last) state_nxt = S_DONE;
				end
			end
			S_DRAIN: begin
				rx_tready = 1'b1;
				if (rx_tvalid && rx_last) state_nxt = S_DONE;
			end
			S_DONE: if (tx_free) state_nxt = S_IDLE; // final reply word has gone
			default: state_nxt = S_IDLE;
		endcase
	end

	//////////////////////////////
	// state and tracking registers
	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= S_IDLE;
			tx_tvalid <= 1'b0;
			word_idx  <= 2'd0;
			err       <= 1'b0;
			rx_ended  <= 1'b0;
		end else begin
			state <= state_nxt;
			if (tx_load)
				tx_tvalid <= 1'b1;                // word valid one cycle after load
			else if (tx_tready)
				tx_tvalid <= 1'b0;
			if (state != S_SEND)
				word_idx <= 2'd0;
			else if (tx_load)
				word_idx <= word_idx + 2'd1;
			if (state == S_IDLE)
				rx_ended <= 1'b0;
			else if (rx_tvalid && rx_tready && rx_last)
				rx_ended <= 1'b1;
			case (state)
				S_IDLE:       err <= 1'b0;
				S_DISPATCH:   if ((is_rd || is_wr) && rx_ended) err <= 1'b1; // no number
				S_GET_NUM:    if (rx_tvalid && is_wr && rx_last) err <= 1'b1; // no data
				S_REG_ACCESS: err <= illegal_reg_num;
				default:      err <= err;
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/cmd_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_top
	import cmd_pkg::*, reg_pkg::*;
#(
	parameter int    NUM_CTRL_REGS = 4,               // writable registers, up to MAX_CTRL_REGS
	parameter word_t FW_VERSION    = 32'h0001_0003    // value of REG_VERSION
) (
	input  wire logic     clk,
	input  wire logic     reset,                      // synchronous, active high
	// receive stream
	input  wire rx_beat_t rx,                         // data and last
	input  wire logic     rx_tvalid,
	output logic          rx_tready,
	// transmit stream
	output tx_beat_t      tx,                         // data and last
	output logic          tx_tvalid,
	input  wire logic     tx_tready,
	// board and status
	input  wire logic [2:0] ch_addr,                  // channel address jumpers
	output ctrl_regs_t    ctrl_regs,                  // writable control registers
	output logic          command_idle                // high between frames
);

	logic      load_csn;                              // latch CSN word
	logic      load_cmd;                              // latch CC word
	tx_sel_t   tx_sel;                                // next transmit word source
	logic      tx_load;                               // register next transmit word
	logic      tx_last_in;                            // last flag for that word
	cmd_code_t cmd_code;                              // latched command code
	reg_req_t  reg_req;                               // register bank strobes
	logic      illegal_reg_num;                       // latched number out of range
	word_t     reg_rd_data;                           // register read data

	//////////////////////////////
	// control
	cmd_dispatch_sm cmd_dispatch_sm0 (
		.clk            (clk),
		.reset          (reset),
		.rx_last        (rx.last),
		.rx_tvalid      (rx_tvalid),
		.rx_tready      (rx_tready),
		.tx_tready      (tx_tready),
		.tx_tvalid      (tx_tvalid),
		.cmd_code       (cmd_code),
		.illegal_reg_num(illegal_reg_num),
		.load_csn       (load_csn),
		.load_cmd       (load_cmd),
		.tx_sel         (tx_sel),
		.tx_load        (tx_load),
		.tx_last_in     (tx_last_in),
		.reg_req        (reg_req),
		.command_idle   (command_idle)
	);

	//////////////////////////////
	// transmit datapath
	tx_frame_builder tx_frame_builder0 (
		.clk        (clk),
		.reset      (reset),
		.rx_data    (rx.data),
		.load_csn   (load_csn),
		.load_cmd   (load_cmd),
		.tx_sel     (tx_sel),
		.tx_load    (tx_load),
		.tx_last_in (tx_last_in),
		.reg_rd_data(reg_rd_data),
		.cmd_code   (cmd_code),
		.tx         (tx)
	);

	//////////////////////////////
	// registers
	register_bank #(
		.NUM_CTRL_REGS(NUM_CTRL_REGS),
		.FW_VERSION   (FW_VERSION)
	) register_bank0 (
		.clk            (clk),
		.reset          (reset),
		.rx_data        (rx.data),
		.reg_req        (reg_req),
		.ch_addr        (ch_addr),
		.illegal_reg_num(illegal_reg_num),
		.reg_rd_data    (reg_rd_data),
		.ctrl_regs      (ctrl_regs)
	);

endmodule

`default_nettype wire

/* verification/cmd_top_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_top_tb
	import cmd_pkg::*, reg_pkg::*;
();

	localparam int    NUM_CTRL_REGS = 4;
	localparam word_t FW_VERSION    = 32'h0001_0003;

	logic clk = 1'b0;
	logic reset;
	rx_beat_t rx;
	logic rx_tvalid, rx_tready;
	tx_beat_t tx;
	logic tx_tvalid, tx_tready;
	logic [2:0] ch_addr;
	ctrl_regs_t ctrl_regs;
	logic command_idle;

	integer     seed = 89;
	word_t      stim_data[$];                     // all frames back to back
	logic       stim_last[$];                     // marks the final word of each frame
	logic [2:0] frame_ch[$];                      // jumper value per frame
	word_t      frm[$];                           // frame under construction
	word_t      cur[$];                           // frame being driven
	word_t      exp_data[$];                      // expected reply words
	logic       exp_last[$];
	ctrl_regs_t model_ctrl = '0;                  // expected control registers
	int         value_errs = 0;
	int         frame_errs = 0;
	int         cycles = 0;
	int         limit = 0;
	word_t      e_data;
	logic       e_last;

	cmd_top #(.NUM_CTRL_REGS(NUM_CTRL_REGS), .FW_VERSION(FW_VERSION)) dut0 (
		.clk(clk), .reset(reset), .rx(rx), .rx_tvalid(rx_tvalid), .rx_tready(rx_tready),
		.tx(tx), .tx_tvalid(tx_tvalid), .tx_tready(tx_tready), .ch_addr(ch_addr),
		.ctrl_regs(ctrl_regs), .command_idle(command_idle)
	);

	initial begin
		forever #50 clk = ~clk;                   // 100 ns period
	end

	//////////////////////////////
	// frame generation
	function automatic int unsigned pick(input int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic word_t make_cc(input cmd_code_t code);
		word_t w;
		w      = $random(seed);                   // upper bits carry no meaning
		w[4:0] = code;
		return w;
	endfunction

	task automatic push_frame(input logic [2:0] ch);
		foreach (frm[i]) begin
			stim_data.push_back(frm[i]);
			stim_last.push_back(i == frm.size() - 1);
		end
		frame_ch.push_back(ch);
		frm.delete();
	endtask

	task automatic add_frame(input cmd_code_t code, input int len, input logic [2:0] ch);
		frm.push_back($random(seed));             // csn
		frm.push_back(make_cc(code));
		for (int i = 2; i < len; i++) frm.push_back($random(seed));
		push_frame(ch);
	endtask

	task automatic add_reg(input cmd_code_t code, input reg_num_t num, input logic [2:0] ch);
		frm.push_back($random(seed));
		frm.push_back(make_cc(code));
		frm.push_back({24'd0, num});
		if (code == CC_WR_REG) frm.push_back($random(seed)); // write data
		push_frame(ch);
	endtask

	task automatic build_stimulus();
		add_frame(CC_LOOPBACK, 2, 3'd0);          // header only
		add_frame(CC_LOOPBACK, 3, 3'd1);
		add_frame(CC_LOOPBACK, 8, 3'd2);
		for (int r = 2; r < 2 + NUM_CTRL_REGS; r++) add_reg(CC_WR_REG, r, 3'd0);
		for (int r = 2; r < 2 + NUM_CTRL_REGS; r++) add_reg(CC_RD_REG, r, 3'd4);
		add_reg(CC_WR_REG, REG_CH_ADDR, 3'd1);    // accepted with no effect
		add_reg(CC_WR_REG, REG_VERSION, 3'd1);
		add_reg(CC_RD_REG, REG_CH_ADDR, 3'd6);    // jumper 6 reads as 3
		add_reg(CC_RD_REG, REG_CH_ADDR, 3'd5);
		add_reg(CC_RD_REG, REG_VERSION, 3'd7);
		add_reg(CC_RD_REG, 8'd6, 3'd0);           // first number out of range
		add_reg(CC_RD_REG, 8'd200, 3'd0);
		add_reg(CC_WR_REG, 8'd7, 3'd0);
		add_reg(CC_WR_REG, 8'd255, 3'd0);
		add_frame(5'd3, 4, 3'd0);                 // unknown codes around good frames
		add_frame(CC_LOOPBACK, 4, 3'd0);
		add_frame(5'd31, 2, 3'd0);
		add_reg(CC_RD_REG, 8'd2, 3'd0);
		add_frame(5'd17, 6, 3'd0);
		add_reg(CC_WR_REG, 8'd3, 3'd0);
		repeat (24) begin
			case (pick(4))
				0: add_frame(CC_LOOPBACK, 2 + pick(7), pick(8));
				1: add_reg(CC_RD_REG, pick(8), pick(8));
				2: add_reg(CC_WR_REG, pick(8), pick(8));
				default: add_frame(3 + pick(29), 2 + pick(4), pick(8));
			endcase
		end
	endtask

	//////////////////////////////
	// reference model
	function automatic void push_exp(input word_t d, input logic l);
		exp_data.push_back(d);
		exp_last.push_back(l);
	endfunction

	function automatic void ref_reply(input logic [2:0] ch);
		word_t    csn;
		word_t    cc;
		reg_num_t num;
		word_t    value;
		logic     legal;
		csn   = cur[0];
		cc    = cur[1];
		num   = (cur.size() > 2) ? cur[2][7:0] : 8'd0;
		legal = (num < 2 + NUM_CTRL_REGS);
		if (num == 0)
			value = {29'd0, ((ch == 3'd6) ? 3'd3 : ch)}; // jumper correction
		else if (num == 1)
			value = FW_VERSION;
		else
			value = legal ? model_ctrl[num - 2] : '0;
		case (cc[4:0])
			CC_LOOPBACK: begin
				push_exp(csn, 1'b0);
				push_exp(cc, cur.size() == 2);
				for (int i = 2; i < cur.size(); i++) push_exp(cur[i], i == cur.size() - 1);
			end
			CC_RD_REG: begin
				push_exp(csn, 1'b0);
				if (legal) begin
					push_exp(cc, 1'b0);
					push_exp(value, 1'b1);
				end else begin
					push_exp(~cc, 1'b1);          // error reply
				end
			end
			CC_WR_REG: begin
				push_exp(csn, 1'b0);
				push_exp(legal ? cc : ~cc, 1'b1);
				if (legal && num >= 2) model_ctrl[num - 2] = cur[3];
			end
			default: ;                            // dropped with no reply
		endcase
	endfunction

	//////////////////////////////
	// driving and frame-level checks
	task automatic send_word(input word_t w, input logic l);
		rx.data   = w;
		rx.last   = l;
		rx_tvalid = 1'b1;
		do @(posedge clk); while (!rx_tready);    // transfer on this edge
		@(negedge clk);
	endtask

	task automatic check_ctrl();
		for (int i = 0; i < NUM_CTRL_REGS; i++) begin
			if (ctrl_regs[i] !== model_ctrl[i]) begin
				$display("[ERROR] %0t ctrl_regs[%0d]: got %h, expected %h", $time, i,
					ctrl_regs[i], model_ctrl[i]);
				value_errs++;
			end
		end
	endtask

	initial begin : stimulus
		int idx;
		rx        = '0;
		rx_tvalid = 1'b0;
		tx_tready = 1'b0;
		ch_addr   = 3'd0;
		reset     = 1'b1;
		idx       = 0;
		build_stimulus();
		limit = 40 * stim_data.size() + 200;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(posedge clk);
		if (command_idle !== 1'b1 || rx_tready !== 1'b0 || tx_tvalid !== 1'b0) begin
			$display("%0t: DUT handshake or idle outputs wrong after reset", $time);
			frame_errs++;
		end
		check_ctrl();
		@(negedge clk);
		foreach (frame_ch[f]) begin
			cur.delete();
			do begin
				cur.push_back(stim_data[idx]);
				idx++;
			end while (!stim_last[idx - 1]);
			ch_addr = frame_ch[f];
			ref_reply(frame_ch[f]);
			for (int i = 0; i < cur.size(); i++) send_word(cur[i], i == cur.size() - 1);
			rx_tvalid = 1'b0;
			do @(posedge clk); while (!command_idle); // end of frame
			if (exp_data.size() != 0) begin
				$display("%0t: reply to frame %0d ended %0d words short", $time, f,
					exp_data.size());
				frame_errs++;
				exp_data.delete();
				exp_last.delete();
			end
			check_ctrl();
			@(negedge clk);
		end
		$display("errors: %0d value mismatches, %0d frame errors", value_errs, frame_errs);
		if (value_errs + frame_errs == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// sink back-pressure with ready three cycles in four on average
	always @(negedge clk) begin
		tx_tready = (($random(seed) & 3) != 0);
	end

	//////////////////////////////
	// transmit comparison
	always @(posedge clk) begin
		if (!reset && tx_tvalid && tx_tready) begin
			if (exp_data.size() == 0) begin
				$display("%0t: DUT sent word %h where no reply word was expected", $time,
					tx.data);
				frame_errs++;
			end else begin
				e_data = exp_data.pop_front();
				e_last = exp_last.pop_front();
				if (tx.data !== e_data) begin
					$display("[ERROR] %0t tx.data: got %h, expected %h", $time, tx.data, e_data);
					value_errs++;
				end
				if (tx.last !== e_last) begin
					$display("[ERROR] %0t tx.last: got %b, expected %b", $time, tx.last, e_last);
					value_errs++;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("run stopped after %0d cycles, DUT did not finish all frames", cycles);
			$display("errors: %0d value mismatches, %0d frame errors", value_errs, frame_errs);
			$display("Test failed");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* cmd_link.f */
common/cmd_pkg.sv
common/reg_pkg.sv
register_bank/register_bank.sv
rtl/tx_frame_builder.sv
rtl/cmd_dispatch_sm.sv
rtl/cmd_top.sv
verification/cmd_top_tb.sv
